//--- busTypes.sv
package busTypes;

    // width of the shared bus and of every general register
    localparam int WordWidth = 32;

    // what drives the shared bus in the current step
    typedef enum logic [2:0] {
        srcNone  = 3'd0,  // bus reads as zero
        srcReg   = 3'd1,  // selected general register
        srcPc    = 3'd2,
        srcMdr   = 3'd3,
        srcZ     = 3'd4,
        srcConst = 3'd5   // sign-extended immediate from the IR
    } busSourceType;

endpackage

//--- cpuTypes.sv
package cpuTypes;

    localparam int ConstWidth = 19;  // immediate field of the I-format

    // opcode values follow the classic 5-bit numbering
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opAddi = 5'b01100,
        opOri  = 5'b01110,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcodeType;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOpType;

    typedef struct packed {
        opcodeType   opcode;
        logic [3:0]  ra;       // destination
        logic [3:0]  rb;       // first operand
        logic [3:0]  rc;       // second operand
        logic [14:0] unused;
    } rFormatType;

    typedef struct packed {
        opcodeType             opcode;
        logic [3:0]            ra;
        logic [3:0]            rb;
        logic [ConstWidth-1:0] constant;  // sign-extended when used
    } iFormatType;

    // one fetched word, read either as register or as immediate form
    typedef union packed {
        rFormatType rFormat;
        iFormatType iFormat;
    } instructionWord;

endpackage

//--- datapathControl.sv
`timescale 1ns/1ps

interface datapathControl import busTypes::*, cpuTypes::*; ();

    busSourceType busSource;
    logic [3:0]   regSelect;  // register index for both read and write
    logic         regOut;
    logic         regLoad;
    logic         pcLoad;
    logic         incPc;
    logic         irLoad;
    logic         yLoad;
    logic         zLoad;
    aluOpType     aluOp;
    logic         marLoad;
    logic         mdrLoad;
    logic         outLoad;

    modport sequencer (
        output busSource, regSelect, regOut, regLoad,
        output pcLoad, incPc, irLoad,
        output yLoad, zLoad, aluOp,
        output marLoad, mdrLoad, outLoad
    );

    modport registers (input busSource, regSelect, regOut, regLoad);

    modport alu (input yLoad, zLoad, aluOp);

    modport fetch (input pcLoad, incPc, irLoad);

    modport memio (input marLoad, mdrLoad, outLoad);

endinterface

//--- controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import busTypes::*, cpuTypes::*; (
    input  logic           Clock,
    input  logic           reset,
    input  instructionWord ir,
    output logic           memRead,
    output logic           halted,
    datapathControl.sequencer ctrl
);

    typedef enum logic [2:0] {
        stepT0 = 3'd0,
        stepT1 = 3'd1,
        stepT2 = 3'd2,
        stepT3 = 3'd3,
        stepT4 = 3'd4,
        stepT5 = 3'd5,
        stepT6 = 3'd6
    } stepType;

    stepType   step;
    logic      haltLatch;
    opcodeType opcode;
    logic      isAluInstr;   // goes through Y, Z and writes ra
    logic      isImmediate;  // second operand is the constant
    aluOpType  decodedOp;

    assign opcode = ir.rFormat.opcode;

    // opcode decode, only meaningful once the IR has loaded in T3
    always_comb begin
        isAluInstr  = 1'b1;
        isImmediate = 1'b0;
        decodedOp   = aluAdd;
        case (opcode)
            opAdd:  decodedOp = aluAdd;
            opSub:  decodedOp = aluSub;
            opAnd:  decodedOp = aluAnd;
            opOr:   decodedOp = aluOr;
            opAddi: begin
                decodedOp   = aluAdd;
                isImmediate = 1'b1;
            end
            opOri:  begin
                decodedOp   = aluOr;
                isImmediate = 1'b1;
            end
            default: isAluInstr = 1'b0;  // out, halt and unknown codes
        endcase
    end

    // halt shows in the cycle after T3 and then holds
    assign halted = haltLatch || (step == stepT4 && opcode == opHalt);

    always_ff @(posedge Clock) begin
        if (reset) begin
            step      <= stepT0;
            haltLatch <= 1'b0;
        end else if (!haltLatch) begin
            case (step)
                stepT0: step <= stepT1;
                stepT1: step <= stepT2;
                stepT2: step <= stepT3;
                stepT3: step <= stepT4;
                stepT4: begin
                    if (opcode == opHalt) begin
                        haltLatch <= 1'b1;  // step stays at T4
                    end else if (isAluInstr) begin
                        step <= stepT5;
                    end else begin
                        step <= stepT0;  // out and unknown codes end here
                    end
                end
                stepT5: step <= stepT6;
                default: step <= stepT0;
            endcase
        end
    end

    // per-step control levels
    always_comb begin
        ctrl.busSource = srcNone;
        ctrl.regSelect = ir.rFormat.ra;
        ctrl.regOut    = 1'b0;
        ctrl.regLoad   = 1'b0;
        ctrl.pcLoad    = 1'b0;  // no branches, PC only counts
        ctrl.incPc     = 1'b0;
        ctrl.irLoad    = 1'b0;
        ctrl.yLoad     = 1'b0;
        ctrl.zLoad     = 1'b0;
        ctrl.aluOp     = decodedOp;
        ctrl.marLoad   = 1'b0;
        ctrl.mdrLoad   = 1'b0;
        ctrl.outLoad   = 1'b0;
        memRead        = 1'b0;
        if (!haltLatch) begin
            case (step)
                stepT0: begin
                    ctrl.busSource = srcPc;
                    ctrl.marLoad   = 1'b1;
                    ctrl.incPc     = 1'b1;
                end
                stepT1: memRead = 1'b1;  // address comes from MAR
                stepT2: ctrl.mdrLoad = 1'b1;
                stepT3: begin
                    ctrl.busSource = srcMdr;
                    ctrl.irLoad    = 1'b1;
                end
                stepT4: begin
                    if (opcode == opOut) begin
                        ctrl.busSource = srcReg;
                        ctrl.regOut    = 1'b1;
                        ctrl.outLoad   = 1'b1;
                    end else if (isAluInstr) begin
                        ctrl.busSource = srcReg;
                        ctrl.regSelect = ir.rFormat.rb;
                        ctrl.regOut    = 1'b1;
                        ctrl.yLoad     = 1'b1;
                    end
                end
                stepT5: begin
                    if (isImmediate) begin
                        ctrl.busSource = srcConst;
                    end else begin
                        ctrl.busSource = srcReg;
                        ctrl.regSelect = ir.rFormat.rc;
                        ctrl.regOut    = 1'b1;
                    end
                    ctrl.zLoad = 1'b1;
                end
                default: begin
                    ctrl.busSource = srcZ;  // T6 writes the result back to ra
                    ctrl.regLoad   = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- registerBus.sv
`timescale 1ns/1ps

module registerBus import busTypes::*; (
    input  logic                 Clock,
    input  logic                 reset,
    datapathControl.registers    ctrl,
    input  logic [WordWidth-1:0] pcWord,
    input  logic [WordWidth-1:0] mdrWord,
    input  logic [WordWidth-1:0] zWord,
    input  logic [WordWidth-1:0] constWord,
    output logic [WordWidth-1:0] bus
);

    logic [WordWidth-1:0] regFile [16];
    logic [WordWidth-1:0] regWord;

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regFile[i] <= '0;
            end
        end else if (ctrl.regLoad) begin
            regFile[ctrl.regSelect] <= bus;
        end
    end

    // register read port, quiet unless the sequencer asks for it
    assign regWord = ctrl.regOut ? regFile[ctrl.regSelect] : '0;

    always_comb begin
        case (ctrl.busSource)
            srcReg:   bus = regWord;
            srcPc:    bus = pcWord;
            srcMdr:   bus = mdrWord;
            srcZ:     bus = zWord;
            srcConst: bus = constWord;
            default:  bus = '0;  // srcNone
        endcase
    end

endmodule

//--- aluUnit.sv
`timescale 1ns/1ps

module aluUnit import busTypes::*, cpuTypes::*; (
    input  logic                 Clock,
    input  logic                 reset,
    datapathControl.alu          ctrl,
    input  logic [WordWidth-1:0] bus,
    output logic [WordWidth-1:0] zWord
);

    logic [WordWidth-1:0] yReg;
    logic [WordWidth-1:0] zReg;
    logic [WordWidth-1:0] aluResult;

    // Y holds the first operand, the bus carries the second
    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = yReg + bus;  // wraps at word width
            aluSub:  aluResult = yReg - bus;
            aluAnd:  aluResult = yReg & bus;
            default: aluResult = yReg | bus;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (ctrl.yLoad) begin
                yReg <= bus;
            end
            if (ctrl.zLoad) begin
                zReg <= aluResult;
            end
        end
    end

    assign zWord = zReg;

endmodule

//--- fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import busTypes::*, cpuTypes::*; #(
    parameter int AddrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 reset,
    datapathControl.fetch        ctrl,
    input  logic [WordWidth-1:0] bus,
    output logic [WordWidth-1:0] pcWord,
    output instructionWord       ir,
    output logic [WordWidth-1:0] constWord
);

    logic [AddrWidth-1:0] pc;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pcLoad) begin
            pc <= bus[AddrWidth-1:0];
        end else if (ctrl.incPc) begin
            pc <= pc + 1'b1;  // word addressed
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.irLoad) begin
            ir <= bus;
        end
    end

    assign pcWord = {{(WordWidth - AddrWidth){1'b0}}, pc};

    // immediate for addi and ori
    assign constWord = {{(WordWidth - ConstWidth){ir.iFormat.constant[ConstWidth-1]}},
                        ir.iFormat.constant};

endmodule

//--- memoryIoUnit.sv
`timescale 1ns/1ps

module memoryIoUnit import busTypes::*; #(
    parameter int AddrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 reset,
    datapathControl.memio        ctrl,
    input  logic [WordWidth-1:0] bus,
    input  logic [WordWidth-1:0] memDataIn,
    output logic [AddrWidth-1:0] memAddress,
    output logic [WordWidth-1:0] mdrWord,
    output logic [WordWidth-1:0] outPort,
    output logic                 outStrobe
);

    always_ff @(posedge Clock) begin
        if (ctrl.marLoad) begin
            memAddress <= bus[AddrWidth-1:0];
        end
        if (ctrl.mdrLoad) begin
            mdrWord <= memDataIn;  // memory answered one cycle after memRead
        end
        if (ctrl.outLoad) begin
            outPort <= bus;
        end
    end

    // strobe lines up with the new outPort value
    always_ff @(posedge Clock) begin
        if (reset) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= ctrl.outLoad;
        end
    end

endmodule

//--- cpuTop.sv
`timescale 1ns/1ps

module cpuTop import busTypes::*, cpuTypes::*; #(
    parameter int AddrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic [WordWidth-1:0] memDataIn,
    output logic [AddrWidth-1:0] memAddress,
    output logic                 memRead,
    output logic [WordWidth-1:0] outPort,
    output logic                 outStrobe,
    output logic                 halted
);

    logic [WordWidth-1:0] bus;
    logic [WordWidth-1:0] pcWord;
    logic [WordWidth-1:0] mdrWord;
    logic [WordWidth-1:0] zWord;
    logic [WordWidth-1:0] constWord;
    instructionWord       ir;

    datapathControl ctrl ();

    controlSequencer sequencer (
        .Clock   (Clock),
        .reset   (reset),
        .ir      (ir),
        .memRead (memRead),
        .halted  (halted),
        .ctrl    (ctrl.sequencer)
    );

    registerBus registers (
        .Clock     (Clock),
        .reset     (reset),
        .ctrl      (ctrl.registers),
        .pcWord    (pcWord),
        .mdrWord   (mdrWord),
        .zWord     (zWord),
        .constWord (constWord),
        .bus       (bus)
    );

    aluUnit alu (
        .Clock (Clock),
        .reset (reset),
        .ctrl  (ctrl.alu),
        .bus   (bus),
        .zWord (zWord)
    );

    fetchUnit #(.AddrWidth(AddrWidth)) fetch (
        .Clock     (Clock),
        .reset     (reset),
        .ctrl      (ctrl.fetch),
        .bus       (bus),
        .pcWord    (pcWord),
        .ir        (ir),
        .constWord (constWord)
    );

    memoryIoUnit #(.AddrWidth(AddrWidth)) memio (
        .Clock      (Clock),
        .reset      (reset),
        .ctrl       (ctrl.memio),
        .bus        (bus),
        .memDataIn  (memDataIn),
        .memAddress (memAddress),
        .mdrWord    (mdrWord),
        .outPort    (outPort),
        .outStrobe  (outStrobe)
    );

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic Clock,
    output logic reset
);

    logic resetLevel = 1'b1;

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;  // 10 ns period
    end

    // power-on reset held over two rising edges
    initial begin
        repeat (2) @(posedge Clock);
        resetLevel <= 1'b0;
    end

    assign reset = resetLevel;

endmodule

//--- cpuTest.sv
`timescale 1ns/1ps

module cpuTest import busTypes::*, cpuTypes::*; ();

    localparam int AddrWidth  = 10;
    localparam int CycleLimit = 2000;  // 6 tests x 40 instructions x 7 cycles, plus margin

    logic                 Clock;
    logic                 startReset;
    logic                 testReset = 1'b0;
    logic                 reset;
    logic [WordWidth-1:0] memDataIn = '0;
    logic [AddrWidth-1:0] memAddress;
    logic                 memRead;
    logic [WordWidth-1:0] outPort;
    logic                 outStrobe;
    logic                 halted;
    logic [WordWidth-1:0] memory [1 << AddrWidth];
    logic [WordWidth-1:0] programWords [$];
    logic [WordWidth-1:0] expectedOut [$];  // outPort values in order
    logic [WordWidth-1:0] modelReg [16];    // register file as the ISA defines it
    int                   cycleCount = 0;
    int                   checkCount = 0;
    int                   errorCount = 0;
    int                   testErrors = 0;
    integer               seed = 32'h5c1b;

    assign reset = startReset || testReset;

    tbClock clockGen (
        .Clock (Clock),
        .reset (startReset)
    );

    cpuTop #(.AddrWidth(AddrWidth)) UUT (
        .Clock      (Clock),
        .reset      (reset),
        .memDataIn  (memDataIn),
        .memAddress (memAddress),
        .memRead    (memRead),
        .outPort    (outPort),
        .outStrobe  (outStrobe),
        .halted     (halted)
    );

    always @(posedge Clock) begin
        if (memRead) begin
            memDataIn <= memory[memAddress];  // word is there one cycle after the strobe
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: run went past %0d cycles without finishing", CycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic checkWord(string name, logic [WordWidth-1:0] got,
                             logic [WordWidth-1:0] expected);
        checkCount++;
        if (got !== expected) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkFlag(string name, logic got, logic expected);
        checkCount++;
        if (got !== expected) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    function automatic logic [WordWidth-1:0] applyOp(opcodeType op, logic [WordWidth-1:0] a,
                                                     logic [WordWidth-1:0] b);
        case (op)
            opAdd, opAddi: return a + b;
            opSub:         return a - b;
            opAnd:         return a & b;
            default:       return a | b;  // or, ori
        endcase
    endfunction

    task automatic newProgram();
        programWords.delete();
        expectedOut.delete();
        foreach (modelReg[i]) begin
            modelReg[i] = '0;
        end
        testErrors = 0;
    endtask

    task automatic emitR(opcodeType op, logic [3:0] ra, logic [3:0] rb, logic [3:0] rc);
        programWords.push_back({op, ra, rb, rc, 15'd0});
        modelReg[ra] = applyOp(op, modelReg[rb], modelReg[rc]);
    endtask

    task automatic emitI(opcodeType op, logic [3:0] ra, logic [3:0] rb, logic [18:0] c);
        programWords.push_back({op, ra, rb, c});
        modelReg[ra] = applyOp(op, modelReg[rb], {{13{c[18]}}, c});
    endtask

    task automatic emitOut(logic [3:0] ra);
        programWords.push_back({opOut, ra, 23'd0});
        expectedOut.push_back(modelReg[ra]);
    endtask

    task automatic applyReset();
        @(posedge Clock);
        testReset <= 1'b1;
        repeat (2) @(posedge Clock);
        testReset <= 1'b0;
    endtask

    task automatic loadAndReset();
        foreach (memory[a]) begin
            memory[a] = {opHalt, 27'(a)};  // stray fetches halt, tagged with their address
        end
        foreach (programWords[i]) begin
            memory[i] = programWords[i];
        end
        applyReset();
    endtask

    task automatic waitForEvent(int limit);
        int waited;
        waited = 0;
        do begin
            @(negedge Clock);
            waited++;
        end while (!outStrobe && !halted && waited < limit);
        if (!outStrobe && !halted) begin
            $display("no output strobe and no halt within %0d cycles at %0t", limit, $time);
            errorCount++;
            testErrors++;
        end
    endtask

    // every expected output in order, then the halt
    task automatic checkRun();
        int limit;
        limit = 7 * programWords.size() + 10;
        foreach (expectedOut[i]) begin
            waitForEvent(limit);
            checkFlag("outStrobe", outStrobe, 1'b1);
            checkWord("outPort", outPort, expectedOut[i]);
        end
        waitForEvent(limit);
        checkFlag("outStrobe", outStrobe, 1'b0);
        checkFlag("halted", halted, 1'b1);
    endtask

    task automatic testAddiConstants();
        newProgram();
        emitI(opAddi, 4'd1, 4'd0, 19'd5);
        emitI(opAddi, 4'd2, 4'd0, 19'h7fffd);  // -3
        emitI(opAddi, 4'd3, 4'd2, 19'h40000);  // most negative constant
        emitOut(4'd1);
        emitOut(4'd2);
        emitOut(4'd3);
        programWords.push_back({opHalt, 27'd0});
        loadAndReset();
        checkRun();
        $display("addi constants: %0d errors", testErrors);
    endtask

    task automatic testAddSub();
        newProgram();
        emitI(opAddi, 4'd6, 4'd0, 19'h7ffff);
        emitI(opAddi, 4'd7, 4'd0, 19'd1);
        emitR(opAdd, 4'd8, 4'd6, 4'd7);  // all ones plus one wraps to zero
        emitOut(4'd8);
        emitR(opSub, 4'd9, 4'd7, 4'd6);
        emitOut(4'd9);
        emitI(opAddi, 4'd4, 4'd0, 19'd9);
        emitI(opAddi, 4'd5, 4'd0, 19'd14);
        emitR(opSub, 4'd0, 4'd4, 4'd5);  // R0 := R4 - R5 goes negative
        emitOut(4'd0);
        programWords.push_back({opHalt, 27'd0});
        loadAndReset();
        checkRun();
        $display("add and sub: %0d errors", testErrors);
    endtask

    task automatic testAndOrRandom();
        newProgram();
        repeat (3) begin
            emitI(opAddi, 4'd1, 4'd0, 19'($random(seed)));
            emitI(opAddi, 4'd2, 4'd0, 19'($random(seed)));
            emitR(opAdd, 4'd3, 4'd1, 4'd2);
            emitR(opAnd, 4'd4, 4'd3, 4'd1);
            emitR(opOr, 4'd5, 4'd3, 4'd2);
            emitOut(4'd4);
            emitOut(4'd5);
        end
        programWords.push_back({opHalt, 27'd0});
        loadAndReset();
        checkRun();
        $display("and and or, random operands: %0d errors", testErrors);
    endtask

    task automatic testOriChains();
        newProgram();
        emitI(opAddi, 4'd1, 4'd0, 19'd3);
        emitI(opOri, 4'd2, 4'd1, 19'h00150);
        emitR(opAdd, 4'd3, 4'd2, 4'd1);
        emitR(opSub, 4'd4, 4'd3, 4'd2);
        emitR(opOr, 4'd5, 4'd4, 4'd3);
        emitI(opOri, 4'd6, 4'd5, 19'h7ff00);
        emitR(opAdd, 4'd7, 4'd6, 4'd5);
        emitR(opSub, 4'd7, 4'd7, 4'd1);  // reads and writes the same register
        emitOut(4'd7);
        programWords.push_back({opHalt, 27'd0});
        loadAndReset();
        checkRun();
        $display("ori and dependency chains: %0d errors", testErrors);
    endtask

    task automatic testHalt();
        newProgram();
        emitI(opAddi, 4'd1, 4'd0, 19'd7);
        emitOut(4'd1);
        programWords.push_back({opHalt, 27'd0});
        programWords.push_back({opOut, 4'd1, 23'd0});  // never reached
        loadAndReset();
        checkRun();
        repeat (20) begin
            @(negedge Clock);
            checkFlag("outStrobe", outStrobe, 1'b0);
            checkFlag("memRead", memRead, 1'b0);
            checkFlag("halted", halted, 1'b1);
        end
        $display("halt: %0d errors", testErrors);
    endtask

    task automatic testResetRestart();
        int waited;
        newProgram();
        emitI(opAddi, 4'd1, 4'd0, 19'd11);
        emitOut(4'd1);
        emitI(opAddi, 4'd2, 4'd1, 19'd22);
        emitOut(4'd2);
        programWords.push_back({opHalt, 27'd0});
        loadAndReset();
        waitForEvent(7 * programWords.size());
        applyReset();  // second addi is being fetched
        waited = 0;
        do begin
            @(negedge Clock);
            waited++;
        end while (!memRead && waited < 10);
        checkFlag("memRead", memRead, 1'b1);
        checkWord("memAddress", WordWidth'(memAddress), '0);
        checkRun();
        $display("reset mid program: %0d errors", testErrors);
    endtask

    initial begin
        while (startReset !== 1'b0) @(posedge Clock);
        testAddiConstants();
        testAddSub();
        testAndOrRandom();
        testOriChains();
        testHalt();
        testResetRestart();
        $display("6 tests, %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
busTypes.sv
cpuTypes.sv
datapathControl.sv
controlSequencer.sv
registerBus.sv
aluUnit.sv
fetchUnit.sv
memoryIoUnit.sv
cpuTop.sv
tbClock.sv
cpuTest.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide from the log
verilator --binary --timing -f list.f --top-module cpuTest -o cpuSim \
    && ./obj_dir/cpuSim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
